/* bench/pipeline_checker.sv */
module pipeline_checker
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wb_valid,
    input  logic [pipe_pkg::reg_idx_width-1:0] wb_rd,
    input  logic [pipe_pkg::xlen-1:0]          wb_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_pkg::*;

    // Expected writebacks in program order
    logic [reg_idx_width-1:0] exp_rd_q [$];
    logic [xlen-1:0]          exp_data_q [$];

    int outstanding = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int wb_count    = 0;
    int entry_num   = 0;

    // Queue one expected register write
    task expect_write(input logic [reg_idx_width-1:0] rd, input logic [xlen-1:0] data);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        outstanding++;
    endtask

    // Failure that is not a wrong value
    task record_failure(input string what);
        $display("check failed: %s", what);
        fail_count++;
    endtask

    // Anything left in the queue never came out of writeback
    task report_missing();
        logic [reg_idx_width-1:0] rd;
        while (exp_rd_q.size() > 0)
        begin
            rd = exp_rd_q.pop_front();
            void'(exp_data_q.pop_front());
            outstanding--;
            record_failure($sformatf("writeback to x%0d never arrived", rd));
        end
    endtask

    // Writeback outputs are registered, mid-cycle they are settled
    always @(negedge clk)
    begin
        logic [reg_idx_width-1:0] want_rd;
        logic [xlen-1:0]          want_data;
        bit                       ok;
        if (!reset && wb_valid)
        begin
            wb_count++;
            if (exp_rd_q.size() == 0)
            begin
                record_failure($sformatf("unexpected extra writeback to x%0d at %0d ns",
                                         wb_rd, $time));
            end
            else
            begin
                want_rd   = exp_rd_q.pop_front();
                want_data = exp_data_q.pop_front();
                outstanding--;
                entry_num++;
                ok = 1'b1;
                if (wb_rd !== want_rd)
                begin
                    $display("[ERROR] %0d ns: wb_rd expected x%0d, got x%0d",
                             $time, want_rd, wb_rd);
                    ok = 1'b0;
                end
                if (wb_data !== want_data)
                begin
                    $display("[ERROR] %0d ns: wb_data expected 0x%08h, got 0x%08h",
                             $time, want_data, wb_data);
                    ok = 1'b0;
                end
                if (ok)
                begin
                    pass_count++;
                    $display("writeback %0d ok: x%0d = 0x%08h", entry_num, wb_rd, wb_data);
                end
                else
                begin
                    fail_count++;
                end
            end
        end
    end

endmodule

/* bench/pipeline_core_tb.sv */
module pipeline_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_pkg::*;

    logic                     clk;
    logic                     reset;
    logic                     instr_valid;
    logic [xlen-1:0]          instr_data;
    logic                     instr_ready;
    logic                     wb_valid;
    logic [reg_idx_width-1:0] wb_rd;
    logic [xlen-1:0]          wb_data;

    // One instruction and its expected writeback per table entry
    logic [xlen-1:0]          tab_instr [$];
    bit                       tab_has_wb [$];
    logic [reg_idx_width-1:0] tab_rd [$];
    logic [xlen-1:0]          tab_data [$];

    int unsigned rng_state;
    int          ready_drops;
    int          expected_total;
    int          gap;

    pipeline_core #(.dmem_words(64)) pipeline_core_i
    (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    pipeline_checker pipeline_checker_i
    (
        .clk      (clk),
        .reset    (reset),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    // RV32I R-type word
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'(op_reg)};
    endfunction

    // I-type word for immediate ALU ops and loads
    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // S-type word store
    function automatic logic [31:0] encode_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'(op_store)};
    endfunction

    // Linear congruential generator for the idle gaps
    function int unsigned next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task add_entry(input logic [31:0] instr, input bit has_wb, input logic [4:0] rd,
                   input logic [31:0] data);
        tab_instr.push_back(instr);
        tab_has_wb.push_back(has_wb);
        tab_rd.push_back(rd);
        tab_data.push_back(data);
    endtask

    task build_table();
        // Never-written sources read zero
        add_entry(encode_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), 1, 5'd7, 32'h0);
        add_entry(encode_i(12'd100, 5'd0, 3'b000, 5'd1, op_imm), 1, 5'd1, 32'd100);
        add_entry(encode_i(12'hff9, 5'd0, 3'b000, 5'd2, op_imm), 1, 5'd2, 32'hffff_fff9);
        add_entry(encode_i(12'h035, 5'd0, 3'b000, 5'd3, op_imm), 1, 5'd3, 32'h35);
        // add, sub, and, or, xor, slt
        add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1, 5'd4, 32'h5d);
        add_entry(encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1, 5'd5, 32'h6b);
        add_entry(encode_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd6), 1, 5'd6, 32'h24);
        add_entry(encode_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd8), 1, 5'd8, 32'h75);
        add_entry(encode_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd9), 1, 5'd9, 32'h51);
        add_entry(encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 1, 5'd10, 32'h1);
        add_entry(encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd11), 1, 5'd11, 32'h0);
        // Dependent chain on rs1 and rs2
        add_entry(encode_i(12'd5, 5'd0, 3'b000, 5'd12, op_imm), 1, 5'd12, 32'd5);
        add_entry(encode_i(12'd3, 5'd12, 3'b000, 5'd12, op_imm), 1, 5'd12, 32'd8);
        add_entry(encode_r(7'h00, 5'd12, 5'd1, 3'b000, 5'd13), 1, 5'd13, 32'h6c);
        add_entry(encode_i(12'h0ff, 5'd13, 3'b100, 5'd14, op_imm), 1, 5'd14, 32'h93);
        // Store then load at 0x48 while the store data is still in flight
        add_entry(encode_i(12'h040, 5'd0, 3'b000, 5'd15, op_imm), 1, 5'd15, 32'h40);
        add_entry(encode_sw(12'd8, 5'd14, 5'd15), 0, 5'd0, 32'h0);
        add_entry(encode_i(12'd8, 5'd15, 3'b010, 5'd16, op_load), 1, 5'd16, 32'h93);
        add_entry(encode_r(7'h00, 5'd16, 5'd16, 3'b000, 5'd17), 1, 5'd17, 32'h126);
        // Write to x0 is dropped and x0 still reads zero
        add_entry(encode_i(12'd55, 5'd1, 3'b000, 5'd0, op_imm), 0, 5'd0, 32'h0);
        add_entry(encode_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd18), 1, 5'd18, 32'd100);
        add_entry(encode_i(12'hfff, 5'd2, 3'b010, 5'd19, op_imm), 1, 5'd19, 32'h1);
        add_entry(encode_i(12'h0f0, 5'd2, 3'b111, 5'd20, op_imm), 1, 5'd20, 32'hf0);
        add_entry(encode_r(7'h20, 5'd20, 5'd17, 3'b000, 5'd21), 1, 5'd21, 32'h36);
    endtask

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial
    begin
        reset          = 1'b1;
        instr_valid    = 1'b0;
        instr_data     = '0;
        rng_state      = 55;
        ready_drops    = 0;
        expected_total = 0;
        build_table();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < tab_instr.size(); i++)
        begin
            if (tab_has_wb[i])
            begin
                pipeline_checker_i.expect_write(tab_rd[i], tab_data[i]);
                expected_total++;
            end
            instr_valid = 1'b1;
            instr_data  = tab_instr[i];
            // Ready is settled mid-cycle and the next rising edge takes the word
            while (!instr_ready)
            begin
                ready_drops++;
                @(negedge clk);
            end
            @(negedge clk);
            instr_valid = 1'b0;
            gap = (next_random() >> 16) % 4;
            repeat (gap) @(negedge clk);
        end
        // Give the last writebacks a bounded time to drain
        for (int n = 0; n < 20 && pipeline_checker_i.outstanding > 0; n++)
            @(negedge clk);
        // Room for stray writebacks
        repeat (8) @(negedge clk);
        pipeline_checker_i.report_missing();
        if (pipeline_checker_i.wb_count != expected_total)
            pipeline_checker_i.record_failure($sformatf("%0d writebacks seen, %0d expected",
                                              pipeline_checker_i.wb_count, expected_total));
        if (ready_drops == 0)
            pipeline_checker_i.record_failure("instr_ready never dropped for a dependent");
        $display("tests passed: %0d, failed: %0d",
                 pipeline_checker_i.pass_count, pipeline_checker_i.fail_count);
        if (pipeline_checker_i.fail_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog allows 20 cycles of 10 ns per table entry
    initial
    begin
        #1;
        #(tab_instr.size() * 20 * 10);
        $display("timeout: run did not finish within %0d cycles", tab_instr.size() * 20);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* project.f */
rtl/pipe_pkg.sv
rtl/hazard_unit.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipeline_core.sv
bench/pipeline_checker.sv
bench/pipeline_core_tb.sv

/* rtl/decode_stage.sv */
module decode_stage
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               instr_valid,
    input  logic [pipe_pkg::xlen-1:0]          instr_data,
    input  logic                               stall,
    input  logic [pipe_pkg::xlen-1:0]          rs1_data,
    input  logic [pipe_pkg::xlen-1:0]          rs2_data,
    output logic                               instr_ready,
    output logic                               dec_valid,
    output logic [pipe_pkg::reg_idx_width-1:0] rs1,
    output logic [pipe_pkg::reg_idx_width-1:0] rs2,
    output logic                               dec_uses_rs1,
    output logic                               dec_uses_rs2,
    output logic                               issue_valid,
    output pipe_pkg::alu_op_e                  issue_alu_op,
    output logic [pipe_pkg::reg_idx_width-1:0] issue_rd,
    output logic                               issue_rd_write,
    output logic                               issue_mem_read,
    output logic                               issue_mem_write,
    output logic [pipe_pkg::xlen-1:0]          issue_a,
    output logic [pipe_pkg::xlen-1:0]          issue_b,
    output logic [pipe_pkg::xlen-1:0]          issue_store_data
);
    import pipe_pkg::*;

    logic            running;
    logic [xlen-1:0] instr_reg;
    opcode_e         opcode;
    alu_op_e         alu_op;
    logic            supported;
    logic            rd_write;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] operand_b;

    // Low through reset, then ready unless the held instruction is stalled
    assign instr_ready = running && (!dec_valid || !stall);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running   <= 1'b0;
            dec_valid <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (instr_valid && instr_ready)
                dec_valid <= 1'b1;
            else if (!stall)
                dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid && instr_ready)
            instr_reg <= instr_data;
    end

    // Field extraction
    assign opcode = opcode_e'(instr_reg[6:0]);
    assign rs1    = instr_reg[19:15];
    assign rs2    = instr_reg[24:20];
    assign imm_i  = {{20{instr_reg[31]}}, instr_reg[31:20]};
    assign imm_s  = {{20{instr_reg[31]}}, instr_reg[31:25], instr_reg[11:7]};

    // Opcode class, source use and second operand
    always_comb
    begin
        supported    = 1'b1;
        rd_write     = 1'b1;
        dec_uses_rs2 = 1'b0;
        operand_b    = imm_i;
        case (opcode)
            op_reg:
            begin
                dec_uses_rs2 = 1'b1;
                operand_b    = rs2_data;
            end
            op_imm, op_load:
            begin
                operand_b = imm_i;
            end
            op_store:
            begin
                rd_write     = 1'b0;
                dec_uses_rs2 = 1'b1;
                operand_b    = imm_s;
            end
            default:
            begin
                supported = 1'b0;
                rd_write  = 1'b0;
            end
        endcase
    end

    // Unsupported opcodes read nothing and never stall
    assign dec_uses_rs1 = supported;

    // funct3 selects the ALU operation, funct7 bit 5 marks sub
    always_comb
    begin
        case (instr_reg[14:12])
            3'b000:  alu_op = (opcode == op_reg && instr_reg[30]) ? alu_sub : alu_add;
            3'b010:  alu_op = alu_slt;
            3'b100:  alu_op = alu_xor;
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            default: alu_op = alu_add;
        endcase
        // Address arithmetic for memory ops
        if (opcode == op_load || opcode == op_store)
            alu_op = alu_add;
    end

    // Issue register, a bubble under stall or for an unsupported opcode
    always_ff @(posedge clk)
    begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= dec_valid && !stall && supported;
    end

    always_ff @(posedge clk)
    begin
        issue_alu_op     <= alu_op;
        issue_rd         <= instr_reg[11:7];
        issue_rd_write   <= rd_write;
        issue_mem_read   <= (opcode == op_load);
        issue_mem_write  <= (opcode == op_store);
        issue_a          <= rs1_data;
        issue_b          <= operand_b;
        issue_store_data <= rs2_data;
    end

    // A stalled instruction stays put until it issues
    held_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> dec_valid && $stable(instr_reg)
    );

endmodule

/* rtl/execute_stage.sv */
module execute_stage
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               issue_valid,
    input  pipe_pkg::alu_op_e                  issue_alu_op,
    input  logic [pipe_pkg::reg_idx_width-1:0] issue_rd,
    input  logic                               issue_rd_write,
    input  logic                               issue_mem_read,
    input  logic                               issue_mem_write,
    input  logic [pipe_pkg::xlen-1:0]          issue_a,
    input  logic [pipe_pkg::xlen-1:0]          issue_b,
    input  logic [pipe_pkg::xlen-1:0]          issue_store_data,
    output logic                               ex_valid,
    output logic [pipe_pkg::reg_idx_width-1:0] ex_rd,
    output logic                               ex_rd_write,
    output logic                               ex_mem_read,
    output logic                               ex_mem_write,
    output logic [pipe_pkg::xlen-1:0]          ex_result,
    output logic [pipe_pkg::xlen-1:0]          ex_store_data
);
    import pipe_pkg::*;

    logic [xlen-1:0] alu_result;
    logic            a_less_b;

    // Signed compare for slt and slti
    assign a_less_b = $signed(issue_a) < $signed(issue_b);

    always_comb
    begin
        case (issue_alu_op)
            alu_add: alu_result = issue_a + issue_b;
            alu_sub: alu_result = issue_a - issue_b;
            alu_and: alu_result = issue_a & issue_b;
            alu_or:  alu_result = issue_a | issue_b;
            alu_xor: alu_result = issue_a ^ issue_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, a_less_b};
            default: alu_result = issue_a + issue_b;
        endcase
    end

    // Valid bit follows issue, bubbles pass through as valid low
    always_ff @(posedge clk)
    begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;
    end

    // Result doubles as the byte address for loads and stores
    always_ff @(posedge clk)
    begin
        ex_rd         <= issue_rd;
        ex_rd_write   <= issue_rd_write;
        ex_mem_read   <= issue_mem_read;
        ex_mem_write  <= issue_mem_write;
        ex_result     <= alu_result;
        ex_store_data <= issue_store_data;
    end

endmodule

/* rtl/hazard_unit.sv */
module hazard_unit
(
    input  logic                               clk,
    input  logic                               reset,
    // Instruction waiting in decode
    input  logic                               dec_valid,
    input  logic [pipe_pkg::reg_idx_width-1:0] dec_rs1,
    input  logic [pipe_pkg::reg_idx_width-1:0] dec_rs2,
    input  logic                               dec_uses_rs1,
    input  logic                               dec_uses_rs2,
    // Instruction in execute
    input  logic                               ex_valid,
    input  logic [pipe_pkg::reg_idx_width-1:0] ex_rd,
    input  logic                               ex_rd_write,
    // Instruction in memory
    input  logic                               mem_valid,
    input  logic [pipe_pkg::reg_idx_width-1:0] mem_rd,
    input  logic                               mem_rd_write,
    output logic                               stall
);

    logic ex_writes;
    logic mem_writes;
    logic rs1_hazard;
    logic rs2_hazard;

    // A stage only counts when it holds a real write to a nonzero register
    // Bubbles carry valid low and never match
    assign ex_writes  = ex_valid && ex_rd_write && (ex_rd != '0);
    assign mem_writes = mem_valid && mem_rd_write && (mem_rd != '0);

    // rs1 is read by every supported opcode
    assign rs1_hazard = dec_uses_rs1 && (dec_rs1 != '0) &&
                        ((ex_writes && (dec_rs1 == ex_rd)) ||
                         (mem_writes && (dec_rs1 == mem_rd)));

    // rs2 only for register ops and stores
    assign rs2_hazard = dec_uses_rs2 && (dec_rs2 != '0) &&
                        ((ex_writes && (dec_rs2 == ex_rd)) ||
                         (mem_writes && (dec_rs2 == mem_rd)));

    // Writeback needs no check since the register file passes its write through
    assign stall = dec_valid && (rs1_hazard || rs2_hazard);

    // Bubbles fill execute and memory behind a stall so it clears within two cycles
    stall_clears: assert property (
        @(posedge clk) disable iff (reset)
        (stall && $past(stall)) |=> !stall
    );

endmodule

/* rtl/memory_stage.sv */
module memory_stage
#(
    parameter int dmem_words = 64
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ex_valid,
    input  logic [pipe_pkg::reg_idx_width-1:0] ex_rd,
    input  logic                               ex_rd_write,
    input  logic                               ex_mem_read,
    input  logic                               ex_mem_write,
    input  logic [pipe_pkg::xlen-1:0]          ex_result,
    input  logic [pipe_pkg::xlen-1:0]          ex_store_data,
    output logic                               wb_valid,
    output logic [pipe_pkg::reg_idx_width-1:0] wb_rd,
    output logic [pipe_pkg::xlen-1:0]          wb_data
);
    import pipe_pkg::*;

    localparam int addr_width = $clog2(dmem_words);

    logic [xlen-1:0]       dmem [dmem_words];
    logic [addr_width-1:0] word_idx;
    logic [xlen-1:0]       load_data;

    // Word index, byte offset dropped, upper bits wrap
    assign word_idx  = ex_result[addr_width+1:2];
    assign load_data = dmem[word_idx];

    // Stores land at the end of the memory cycle
    always_ff @(posedge clk)
    begin
        if (ex_valid && ex_mem_write)
            dmem[word_idx] <= ex_store_data;
    end

    // Only real register writes reach writeback
    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_valid && ex_rd_write && (ex_rd != '0);
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= ex_rd;
        wb_data <= ex_mem_read ? load_data : ex_result;
    end

    // Decode never sets both for one instruction
    no_read_and_write: assert property (
        @(posedge clk) disable iff (reset)
        ex_valid |-> !(ex_mem_read && ex_mem_write)
    );

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    // Data and instruction word width
    localparam int xlen = 32;

    // Register index width, x0 to x31
    localparam int reg_idx_width = 5;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0]
    {
        // add, sub, and, or, xor, slt
        op_reg   = 7'b0110011,
        // addi, andi, ori, xori, slti
        op_imm   = 7'b0010011,
        // lw
        op_load  = 7'b0000011,
        // sw
        op_store = 7'b0100011
    } opcode_e;

    // ALU operations
    // Loads and stores use alu_add for the address
    typedef enum logic [2:0]
    {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

endpackage

/* rtl/pipeline_core.sv */
module pipeline_core
#(
    parameter int dmem_words = 64
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               instr_valid,
    input  logic [pipe_pkg::xlen-1:0]          instr_data,
    output logic                               instr_ready,
    output logic                               wb_valid,
    output logic [pipe_pkg::reg_idx_width-1:0] wb_rd,
    output logic [pipe_pkg::xlen-1:0]          wb_data
);
    import pipe_pkg::*;

    // Decode to hazard unit and register file
    logic                     stall;
    logic                     dec_valid;
    logic [reg_idx_width-1:0] rs1;
    logic [reg_idx_width-1:0] rs2;
    logic                     dec_uses_rs1;
    logic                     dec_uses_rs2;
    logic [xlen-1:0]          rs1_data;
    logic [xlen-1:0]          rs2_data;

    // Issue register, the instruction now in execute
    logic                     issue_valid;
    alu_op_e                  issue_alu_op;
    logic [reg_idx_width-1:0] issue_rd;
    logic                     issue_rd_write;
    logic                     issue_mem_read;
    logic                     issue_mem_write;
    logic [xlen-1:0]          issue_a;
    logic [xlen-1:0]          issue_b;
    logic [xlen-1:0]          issue_store_data;

    // Execute register, the instruction now in memory
    logic                     ex_valid;
    logic [reg_idx_width-1:0] ex_rd;
    logic                     ex_rd_write;
    logic                     ex_mem_read;
    logic                     ex_mem_write;
    logic [xlen-1:0]          ex_result;
    logic [xlen-1:0]          ex_store_data;

    decode_stage decode_stage_i (.*);

    // Execute side sees the issue register, memory side the execute register
    hazard_unit hazard_unit_i
    (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec_rs1      (rs1),
        .dec_rs2      (rs2),
        .dec_uses_rs1 (dec_uses_rs1),
        .dec_uses_rs2 (dec_uses_rs2),
        .ex_valid     (issue_valid),
        .ex_rd        (issue_rd),
        .ex_rd_write  (issue_rd_write),
        .mem_valid    (ex_valid),
        .mem_rd       (ex_rd),
        .mem_rd_write (ex_rd_write),
        .stall        (stall)
    );

    execute_stage execute_stage_i (.*);

    memory_stage #(.dmem_words(dmem_words)) memory_stage_i (.*);

    // Writeback port drives the write side directly
    register_file register_file_i
    (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_en    (wb_valid),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

/* rtl/register_file.sv */
module register_file
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic [pipe_pkg::reg_idx_width-1:0] rs1,
    input  logic [pipe_pkg::reg_idx_width-1:0] rs2,
    input  logic                               wr_en,
    input  logic [pipe_pkg::reg_idx_width-1:0] wr_idx,
    input  logic [pipe_pkg::xlen-1:0]          wr_data,
    output logic [pipe_pkg::xlen-1:0]          rs1_data,
    output logic [pipe_pkg::xlen-1:0]          rs2_data
);
    import pipe_pkg::*;

    // Only x1 to x31 are stored
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_idx != '0))
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 reads zero and a same-cycle write is passed through
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && (wr_idx == rs1)) ? wr_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && (wr_idx == rs2)) ? wr_data : regs[rs2];

    // A written register reads back from storage on the following cycle
    write_reads_back: assert property (
        @(posedge clk) disable iff (reset)
        ($past(wr_en) && ($past(wr_idx) != '0) && (rs1 == $past(wr_idx)) &&
         !(wr_en && (wr_idx == rs1)))
        |-> (rs1_data == $past(wr_data))
    );

endmodule
